//--- Bender.yml
package:
  name: cfg_ctrl

sources:
  - src/cfg_bus_pkg.sv
  - src/cfg_map_pkg.sv
  - src/wb_cfg_port.sv
  - src/axil_cfg_port.sv
  - src/cfg_arbiter.sv
  - src/axil_cfg_master.sv
  - src/cfg_target_router.sv
  - src/cfg_ctrl.sv
  - target: test
    files:
      - verification/cfg_target_model.sv
      - verification/tb_cfg_ctrl.sv

//--- cfg_ctrl.f
src/cfg_bus_pkg.sv
src/cfg_map_pkg.sv
src/wb_cfg_port.sv
src/axil_cfg_port.sv
src/cfg_arbiter.sv
src/axil_cfg_master.sv
src/cfg_target_router.sv
src/cfg_ctrl.sv
verification/cfg_target_model.sv
verification/tb_cfg_ctrl.sv

//--- src/axil_cfg_master.sv
`timescale 1ns/100ps
`default_nettype none

module axil_cfg_master (
	input  logic                           axi_clk,
	input  logic                           axi_reset_n,
	input  cfg_bus_pkg::cfg_req_t          req_i,
	input  cfg_bus_pkg::axil_m_rsp_t       rsp_i,
	output cfg_bus_pkg::axil_m_req_t       axi_o,
	output logic                           done_o,
	output logic [cfg_bus_pkg::DATA_W-1:0] rdata_o
);

	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0,
		ST_RD_A  = 3'd1, // arvalid out, waiting arready
		ST_RD_R  = 3'd2, // address taken, waiting rvalid
		ST_WR_AW = 3'd3, // awvalid and wvalid out
		ST_WR_W  = 3'd4  // address taken, waiting wready
	} state_e;

	state_e                           state;
	logic                             awvalid_q;
	logic                             wvalid_q;
	logic                             arvalid_q;
	logic                             rready_q;
	logic [cfg_bus_pkg::M_ADDR_W-1:0] addr_q;
	logic [cfg_bus_pkg::DATA_W-1:0]   wdata_q;
	logic                             issue;
	logic                             rd_fin;

	// Request is still up in the done cycle, so skip it there
	assign issue  = (state == ST_IDLE) && req_i.req && !done_o;
	assign rd_fin = ((state == ST_RD_A) && rsp_i.arready && rsp_i.rvalid) ||
	                ((state == ST_RD_R) && rsp_i.rvalid);

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state     <= ST_IDLE;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
			arvalid_q <= 1'b0;
			rready_q  <= 1'b0;
			done_o    <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (issue && req_i.we) begin
						awvalid_q <= 1'b1;
						wvalid_q  <= 1'b1;
						state     <= ST_WR_AW;
					end else if (issue) begin
						arvalid_q <= 1'b1;
						rready_q  <= 1'b1;
						state     <= ST_RD_A;
					end
				end
				ST_WR_AW: begin
					if (rsp_i.awready && rsp_i.wready) begin
						awvalid_q <= 1'b0;
						wvalid_q  <= 1'b0;
						done_o    <= 1'b1;
						state     <= ST_IDLE;
					end else if (rsp_i.awready) begin
						awvalid_q <= 1'b0;
						state     <= ST_WR_W;
					end
				end
				ST_WR_W: begin
					if (rsp_i.wready) begin
						wvalid_q <= 1'b0;
						done_o   <= 1'b1;
						state    <= ST_IDLE;
					end
				end
				ST_RD_A, ST_RD_R: begin
					if (rd_fin) begin
						arvalid_q <= 1'b0;
						rready_q  <= 1'b0;
						done_o    <= 1'b1;
						state     <= ST_IDLE;
					end else if (state == ST_RD_A && rsp_i.arready) begin
						arvalid_q <= 1'b0;
						state     <= ST_RD_R;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge axi_clk) begin
		if (issue) begin
			addr_q  <= req_i.addr[cfg_bus_pkg::M_ADDR_W-1:0]; // Low 15 bits go out
			wdata_q <= req_i.wdata;
		end
		if (rd_fin) rdata_o <= rsp_i.rdata;
	end

	assign axi_o = '{
		awvalid: awvalid_q,
		awaddr:  addr_q,
		wvalid:  wvalid_q,
		wdata:   wdata_q,
		wstrb:   {cfg_bus_pkg::STRB_W{1'b1}}, // Full word writes only
		arvalid: arvalid_q,
		araddr:  addr_q,
		rready:  rready_q
	};

endmodule

`default_nettype wire

//--- src/axil_cfg_port.sv
`timescale 1ns/100ps
`default_nettype none

module axil_cfg_port (
	input  logic                           axi_clk,
	input  logic                           axi_reset_n,
	input  cfg_bus_pkg::axil_s_req_t       cfg_i,
	output cfg_bus_pkg::axil_s_rsp_t       cfg_o,
	input  logic                           done_i,
	input  logic [cfg_bus_pkg::DATA_W-1:0] rdata_i,
	output cfg_bus_pkg::cfg_req_t          req_o
);

	typedef enum logic [2:0] {
		ST_IDLE    = 3'd0,
		ST_RD_WAIT = 3'd1,
		ST_RD_HOLD = 3'd2,
		ST_WR_DATA = 3'd3,
		ST_WR_WAIT = 3'd4
	} state_e;

	state_e                         state;
	logic                           awready_q;
	logic                           wready_q;
	logic                           arready_q;
	logic                           rvalid_q;
	logic [cfg_bus_pkg::ADDR_W-1:0] addr_q;
	logic [cfg_bus_pkg::DATA_W-1:0] wdata_q;
	logic [cfg_bus_pkg::DATA_W-1:0] rdata_q;
	logic                           rd_done;

	// rready has to be up already when done arrives
	assign rd_done = (state == ST_RD_WAIT) && cfg_i.rready && done_i;

	////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state     <= ST_IDLE;
			awready_q <= 1'b0;
			wready_q  <= 1'b0;
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
		end else begin
			awready_q <= 1'b0; // Readies are single pulses
			wready_q  <= 1'b0;
			arready_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (cfg_i.awvalid) begin // Write first
						awready_q <= 1'b1;
						state     <= ST_WR_DATA;
					end else if (cfg_i.arvalid) begin
						arready_q <= 1'b1;
						state     <= ST_RD_WAIT;
					end
				end
				ST_RD_WAIT: begin
					if (rd_done) begin
						rvalid_q <= 1'b1;
						state    <= ST_RD_HOLD;
					end
				end
				ST_RD_HOLD: begin
					if (cfg_i.rready) begin
						rvalid_q <= 1'b0;
						state    <= ST_IDLE;
					end
				end
				ST_WR_DATA: begin
					if (cfg_i.wvalid) state <= ST_WR_WAIT;
				end
				ST_WR_WAIT: begin
					if (done_i) begin
						wready_q <= 1'b1;
						state    <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Address and data capture
	////////////////////////////////////////
	always_ff @(posedge axi_clk) begin
		if (state == ST_IDLE) begin
			if (cfg_i.awvalid) begin
				addr_q <= cfg_i.awaddr;
			end else if (cfg_i.arvalid) begin
				addr_q <= cfg_i.araddr;
			end
		end
		if (state == ST_WR_DATA && cfg_i.wvalid) wdata_q <= cfg_i.wdata;
		if (rd_done) rdata_q <= rdata_i;
	end

	assign req_o = '{
		req:   (state == ST_RD_WAIT) || (state == ST_WR_WAIT),
		we:    (state == ST_WR_WAIT),
		addr:  addr_q,
		wdata: wdata_q
	};

	assign cfg_o = '{
		rdata:   rdata_q,
		rvalid:  rvalid_q,
		awready: awready_q,
		wready:  wready_q,
		arready: arready_q
	};

endmodule

`default_nettype wire

//--- src/cfg_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module cfg_arbiter (
	input  logic                           axi_clk,
	input  logic                           axi_reset_n,
	input  cfg_bus_pkg::cfg_req_t          wb_req_i,
	input  cfg_bus_pkg::cfg_req_t          fpga_req_i,
	input  logic                           m_done_i,
	input  logic [cfg_bus_pkg::DATA_W-1:0] m_rdata_i,
	output cfg_bus_pkg::cfg_req_t          req_o,
	output logic                           grant_o,
	output logic                           wb_done_o,
	output logic                           fpga_done_o,
	output logic [cfg_bus_pkg::DATA_W-1:0] rdata_o
);

	localparam logic GNT_WB   = 1'b0;
	localparam logic GNT_FPGA = 1'b1;

	logic grant_q;

	// Grant only moves once the holder has dropped its request
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			grant_q <= GNT_WB;
		end else if (grant_q == GNT_WB) begin
			if (!wb_req_i.req && fpga_req_i.req) grant_q <= GNT_FPGA;
		end else begin
			if (!fpga_req_i.req && wb_req_i.req) grant_q <= GNT_WB;
		end
	end

	assign req_o   = (grant_q == GNT_FPGA) ? fpga_req_i : wb_req_i;
	assign grant_o = grant_q;

	// Holder still has its request up when done pulses
	assign wb_done_o   = m_done_i && (grant_q == GNT_WB);
	assign fpga_done_o = m_done_i && (grant_q == GNT_FPGA);
	assign rdata_o     = m_rdata_i; // Each side samples on its own done

endmodule

`default_nettype wire

//--- src/cfg_bus_pkg.sv
`default_nettype none

package cfg_bus_pkg;

	localparam int DATA_W   = 32;
	localparam int ADDR_W   = 32;
	localparam int M_ADDR_W = 15; // Outgoing address keeps the low bits only
	localparam int STRB_W   = 4;

	// Internal request, level held until done
	typedef struct packed {
		logic              req;
		logic              we;    // High for a write
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} cfg_req_t;

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] wdata;
	} wb_req_t;

	////////////////////////////////////////
	// FPGA-side AXI-Lite slave
	////////////////////////////////////////
	typedef struct packed {
		logic              awvalid;
		logic [ADDR_W-1:0] awaddr;
		logic              wvalid;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] wstrb;
		logic              arvalid;
		logic [ADDR_W-1:0] araddr;
		logic              rready;
	} axil_s_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic              rvalid;
		logic              awready;
		logic              wready;
		logic              arready;
	} axil_s_rsp_t;

	////////////////////////////////////////
	// AXI-Lite master toward the targets
	////////////////////////////////////////
	typedef struct packed {
		logic                awvalid;
		logic [M_ADDR_W-1:0] awaddr;
		logic                wvalid;
		logic [DATA_W-1:0]   wdata;
		logic [STRB_W-1:0]   wstrb;
		logic                arvalid;
		logic [M_ADDR_W-1:0] araddr;
		logic                rready;
	} axil_m_req_t;

	// Response of one target, no write-response channel
	typedef struct packed {
		logic              awready;
		logic              wready;
		logic              arready;
		logic [DATA_W-1:0] rdata;
		logic              rvalid;
	} axil_m_rsp_t;

endpackage

`default_nettype wire

//--- src/cfg_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cfg_ctrl #(
	parameter int SEL_W = 5
) (
	input  logic                      axi_clk,
	input  logic                      axi_reset_n,
	input  cfg_bus_pkg::wb_req_t      wb_i,
	output logic                      wb_ack_o,
	output logic [cfg_bus_pkg::DATA_W-1:0] wb_rdata_o,
	input  cfg_bus_pkg::axil_s_req_t  aa_cfg_i,
	output cfg_bus_pkg::axil_s_rsp_t  aa_cfg_o,
	output cfg_bus_pkg::axil_m_req_t  axi_m_o,
	input  cfg_bus_pkg::axil_m_rsp_t  axi_m_i [cfg_map_pkg::N_EXT],
	output logic                      up_en_o,
	output logic                      la_en_o,
	output logic                      aa_en_o,
	output logic                      is_en_o,
	output logic [SEL_W-1:0]          user_prj_sel_o
);

	cfg_bus_pkg::cfg_req_t     wb_req;
	cfg_bus_pkg::cfg_req_t     fpga_req;
	cfg_bus_pkg::cfg_req_t     m_req;    // Granted request
	cfg_bus_pkg::axil_m_rsp_t  m_rsp;    // Merged target response
	logic                      wb_done;
	logic                      fpga_done;
	logic                      m_done;
	logic [cfg_bus_pkg::DATA_W-1:0] m_rdata;
	logic [cfg_bus_pkg::DATA_W-1:0] arb_rdata;
	logic [cfg_map_pkg::N_EXT-1:0]  tgt_en;

	wb_cfg_port wb_port_inst (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.wb_i        (wb_i),
		.done_i      (wb_done),
		.rdata_i     (arb_rdata),
		.req_o       (wb_req),
		.ack_o       (wb_ack_o),
		.rdata_o     (wb_rdata_o)
	);

	axil_cfg_port aa_port_inst (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.cfg_i       (aa_cfg_i),
		.cfg_o       (aa_cfg_o),
		.done_i      (fpga_done),
		.rdata_i     (arb_rdata),
		.req_o       (fpga_req)
	);

	cfg_arbiter arbiter_inst (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.wb_req_i    (wb_req),
		.fpga_req_i  (fpga_req),
		.m_done_i    (m_done),
		.m_rdata_i   (m_rdata),
		.req_o       (m_req),
		.grant_o     (),
		.wb_done_o   (wb_done),
		.fpga_done_o (fpga_done),
		.rdata_o     (arb_rdata)
	);

	axil_cfg_master master_inst (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.req_i       (m_req),
		.rsp_i       (m_rsp),
		.axi_o       (axi_m_o),
		.done_o      (m_done),
		.rdata_o     (m_rdata)
	);

	cfg_target_router #(
		.SEL_W (SEL_W)
	) router_inst (
		.axi_clk        (axi_clk),
		.axi_reset_n    (axi_reset_n),
		.addr_i         (m_req.addr),
		.axi_i          (axi_m_o),
		.tgt_i          (axi_m_i),
		.rsp_o          (m_rsp),
		.en_o           (tgt_en),
		.user_prj_sel_o (user_prj_sel_o)
	);

	assign up_en_o = tgt_en[cfg_map_pkg::TGT_USER];
	assign la_en_o = tgt_en[cfg_map_pkg::TGT_ANLZ];
	assign aa_en_o = tgt_en[cfg_map_pkg::TGT_BRIDGE];
	assign is_en_o = tgt_en[cfg_map_pkg::TGT_SERDES];

endmodule

`default_nettype wire

//--- src/cfg_map_pkg.sv
`default_nettype none

package cfg_map_pkg;

	localparam int PAGE_W = 20; // Address bits 31 to 12
	localparam int OFS_W  = 12; // Offset inside a page

	localparam logic [PAGE_W-1:0] PAGE_USER    = 20'h30000;
	localparam logic [PAGE_W-1:0] PAGE_ANLZ    = 20'h30001;
	localparam logic [PAGE_W-1:0] PAGE_BRIDGE  = 20'h30002;
	localparam logic [PAGE_W-1:0] PAGE_SERDES  = 20'h30003;
	localparam logic [PAGE_W-1:0] PAGE_LOCAL   = 20'h30004;
	localparam logic [PAGE_W-1:0] PAGE_RSVD_LO = 20'h30005;
	localparam logic [PAGE_W-1:0] PAGE_RSVD_HI = 20'h3FFFF;

	localparam int N_EXT = 4;

	// Position of each external target in the enable and response arrays
	typedef enum logic [1:0] {
		TGT_USER   = 2'd0,
		TGT_ANLZ   = 2'd1,
		TGT_BRIDGE = 2'd2,
		TGT_SERDES = 2'd3
	} tgt_idx_e;

	localparam logic [OFS_W-1:0] LOCAL_SEL_OFS = '0;

	localparam logic [cfg_bus_pkg::DATA_W-1:0] RSVD_RDATA = '1;

endpackage

`default_nettype wire

//--- src/cfg_target_router.sv
`timescale 1ns/100ps
`default_nettype none

module cfg_target_router #(
	parameter int SEL_W = 5
) (
	input  logic                           axi_clk,
	input  logic                           axi_reset_n,
	input  logic [cfg_bus_pkg::ADDR_W-1:0] addr_i,
	input  cfg_bus_pkg::axil_m_req_t       axi_i,
	input  cfg_bus_pkg::axil_m_rsp_t       tgt_i [cfg_map_pkg::N_EXT],
	output cfg_bus_pkg::axil_m_rsp_t       rsp_o,
	output logic [cfg_map_pkg::N_EXT-1:0]  en_o,
	output logic [SEL_W-1:0]               user_prj_sel_o
);

	logic [cfg_map_pkg::PAGE_W-1:0] page;
	logic                           local_hit;
	logic                           rsvd_hit;
	logic                           sel_wr;

	////////////////////////////////////////
	// Page decode
	////////////////////////////////////////
	assign page = addr_i[cfg_bus_pkg::ADDR_W-1 -: cfg_map_pkg::PAGE_W];

	assign en_o[cfg_map_pkg::TGT_USER]   = (page == cfg_map_pkg::PAGE_USER);
	assign en_o[cfg_map_pkg::TGT_ANLZ]   = (page == cfg_map_pkg::PAGE_ANLZ);
	assign en_o[cfg_map_pkg::TGT_BRIDGE] = (page == cfg_map_pkg::PAGE_BRIDGE);
	assign en_o[cfg_map_pkg::TGT_SERDES] = (page == cfg_map_pkg::PAGE_SERDES);

	assign local_hit = (page == cfg_map_pkg::PAGE_LOCAL);
	assign rsvd_hit  = (page >= cfg_map_pkg::PAGE_RSVD_LO) &&
	                   (page <= cfg_map_pkg::PAGE_RSVD_HI);

	////////////////////////////////////////
	// Response merge
	////////////////////////////////////////
	always_comb begin
		rsp_o = '0; // Unmapped page, requester stalls
		for (int i = 0; i < cfg_map_pkg::N_EXT; i++) begin
			if (en_o[i]) rsp_o = tgt_i[i]; // Enables are one-hot
		end
		if (local_hit) begin
			rsp_o = '{
				awready: axi_i.awvalid,
				wready:  axi_i.wvalid,
				arready: 1'b1,
				rdata:   cfg_bus_pkg::DATA_W'(user_prj_sel_o),
				rvalid:  1'b1
			};
		end else if (rsvd_hit) begin
			// Reads give all ones, writes complete at once
			rsp_o = '{
				awready: axi_i.awvalid,
				wready:  axi_i.wvalid,
				arready: axi_i.arvalid,
				rdata:   cfg_map_pkg::RSVD_RDATA,
				rvalid:  axi_i.arvalid
			};
		end
	end

	// Project select lives at offset 0 of the local page
	assign sel_wr = local_hit && axi_i.awvalid && axi_i.wvalid && axi_i.wstrb[0] &&
	                (axi_i.awaddr[cfg_map_pkg::OFS_W-1:0] == cfg_map_pkg::LOCAL_SEL_OFS);

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			user_prj_sel_o <= '0;
		end else if (sel_wr) begin
			user_prj_sel_o <= axi_i.wdata[SEL_W-1:0];
		end
	end

endmodule

`default_nettype wire

//--- src/wb_cfg_port.sv
`timescale 1ns/100ps
`default_nettype none

module wb_cfg_port (
	input  logic                           axi_clk,
	input  logic                           axi_reset_n,
	input  cfg_bus_pkg::wb_req_t           wb_i,
	input  logic                           done_i,
	input  logic [cfg_bus_pkg::DATA_W-1:0] rdata_i,
	output cfg_bus_pkg::cfg_req_t          req_o,
	output logic                           ack_o,
	output logic [cfg_bus_pkg::DATA_W-1:0] rdata_o
);

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_BUSY = 1'b1
	} state_e;

	state_e                         state;
	logic                           we_q;
	logic [cfg_bus_pkg::ADDR_W-1:0] addr_q;
	logic [cfg_bus_pkg::DATA_W-1:0] wdata_q;
	logic                           start;

	// No new cycle while the previous ack is out
	assign start = (state == ST_IDLE) && !ack_o && wb_i.cyc && wb_i.stb;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state <= ST_IDLE;
			ack_o <= 1'b0;
		end else begin
			ack_o <= 1'b0;
			if (start) begin
				state <= ST_BUSY;
			end else if (state == ST_BUSY && done_i) begin
				state <= ST_IDLE;
				ack_o <= 1'b1; // One-cycle ack
			end
		end
	end

	always_ff @(posedge axi_clk) begin
		if (start) begin
			we_q    <= wb_i.we;
			addr_q  <= wb_i.adr;
			wdata_q <= wb_i.wdata;
		end
		if (state == ST_BUSY && done_i && !we_q) begin
			rdata_o <= rdata_i; // Valid in the ack cycle
		end
	end

	assign req_o = '{
		req:   (state == ST_BUSY),
		we:    we_q,
		addr:  addr_q,
		wdata: wdata_q
	};

endmodule

`default_nettype wire

//--- verification/cfg_target_model.sv
`timescale 1ns/100ps
`default_nettype none

module cfg_target_model (
	input  logic                          axi_clk,
	input  logic                          axi_reset_n,
	input  cfg_bus_pkg::axil_m_req_t      axi_i,
	input  logic [cfg_map_pkg::N_EXT-1:0] en_i,
	output cfg_bus_pkg::axil_m_rsp_t      rsp_o [cfg_map_pkg::N_EXT]
);

	logic [31:0] regs [cfg_map_pkg::N_EXT];
	logic        wr_ack;
	logic        rd_ack;
	logic [31:0] rdata_q;
	logic [1:0]  wait_q; // Cycles left before the next ready
	logic [31:0] lcg_q;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			for (int i = 0; i < cfg_map_pkg::N_EXT; i++) regs[i] <= i * 32'h1111_1111;
			wr_ack  <= 1'b0;
			rd_ack  <= 1'b0;
			rdata_q <= '0;
			wait_q  <= '0;
			lcg_q   <= 32'd12895;
		end else begin
			wr_ack <= 1'b0; // Single pulses
			rd_ack <= 1'b0;
			for (int i = 0; i < cfg_map_pkg::N_EXT; i++) begin
				if (en_i[i] && axi_i.awvalid && axi_i.wvalid && !wr_ack) begin
					if (wait_q == 0) begin
						wr_ack  <= 1'b1;
						regs[i] <= axi_i.wdata;
						lcg_q   <= lcg_next(lcg_q);
						wait_q  <= lcg_q[17:16]; // Next delay, 0 to 3
					end else begin
						wait_q <= wait_q - 2'd1;
					end
				end else if (en_i[i] && axi_i.arvalid && !rd_ack) begin
					if (wait_q == 0) begin
						rd_ack  <= 1'b1;
						rdata_q <= regs[i];
						lcg_q   <= lcg_next(lcg_q);
						wait_q  <= lcg_q[17:16];
					end else begin
						wait_q <= wait_q - 2'd1;
					end
				end
			end
		end
	end

	// Address and data accepted together, read data with arready
	always_comb begin
		for (int i = 0; i < cfg_map_pkg::N_EXT; i++) begin
			rsp_o[i] = '0;
			if (en_i[i]) begin
				rsp_o[i] = '{
					awready: wr_ack,
					wready:  wr_ack,
					arready: rd_ack,
					rdata:   rdata_q,
					rvalid:  rd_ack
				};
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/tb_cfg_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cfg_ctrl;

	localparam int MAX_CYCLES = 4000; // About ten times the expected traffic

	logic                     axi_clk;
	logic                     axi_reset_n;
	cfg_bus_pkg::wb_req_t     wb;
	logic                     wb_ack;
	logic [31:0]              wb_rdata;
	cfg_bus_pkg::axil_s_req_t aa_req;
	cfg_bus_pkg::axil_s_rsp_t aa_rsp;
	cfg_bus_pkg::axil_m_req_t axi_m;
	cfg_bus_pkg::axil_m_rsp_t tgt_rsp [cfg_map_pkg::N_EXT];
	logic                     up_en;
	logic                     la_en;
	logic                     aa_en;
	logic                     is_en;
	logic [4:0]               user_prj_sel;
	logic [3:0]               tgt_en;
	logic                     any_rvalid;
	logic                     m_active;

	int          value_errs = 0;
	int          other_errs = 0;
	int          cycles = 0;
	int          wb_issued = 0;
	int          wb_acks = 0;
	int          aa_issued = 0;
	int          aa_dones = 0;
	int          m_issues = 0;
	logic        m_active_q = 1'b0;
	logic        started = 1'b0;  // First request driven
	logic [3:0]  en_mask = '0;    // Enables allowed for the traffic in flight
	logic        addr_chk = 1'b0;
	logic [14:0] exp_addr = '0;
	logic        wb_chk = 1'b0;
	logic [31:0] wb_exp = '0;
	logic        aa_chk = 1'b0;
	logic [31:0] aa_exp = '0;
	logic [4:0]  sel_shadow = '0;
	logic [31:0] shadow [4];
	logic [31:0] lcg_state = 32'd12895;

	always #10 axi_clk = ~axi_clk;

	cfg_ctrl #(.SEL_W(5)) cfg_ctrl_inst (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n),
		.wb_i(wb), .wb_ack_o(wb_ack), .wb_rdata_o(wb_rdata),
		.aa_cfg_i(aa_req), .aa_cfg_o(aa_rsp),
		.axi_m_o(axi_m), .axi_m_i(tgt_rsp),
		.up_en_o(up_en), .la_en_o(la_en), .aa_en_o(aa_en), .is_en_o(is_en),
		.user_prj_sel_o(user_prj_sel)
	);

	cfg_target_model target_model_inst (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n),
		.axi_i(axi_m), .en_i(tgt_en), .rsp_o(tgt_rsp)
	);

	assign tgt_en     = {is_en, aa_en, la_en, up_en};
	assign any_rvalid = tgt_rsp[0].rvalid | tgt_rsp[1].rvalid |
	                    tgt_rsp[2].rvalid | tgt_rsp[3].rvalid;
	assign m_active   = axi_m.awvalid || axi_m.wvalid || axi_m.arvalid;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// One-hot enable of an external page or zero
	function automatic logic [3:0] page_mask(input logic [31:0] addr);
		logic [19:0] page;
		page = addr[31:12];
		if (page >= 20'h30000 && page <= 20'h30003) return 4'b0001 << (page - 20'h30000);
		return 4'b0000;
	endfunction

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	a_reset_quiet: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		!started |-> !axi_m.awvalid && !axi_m.wvalid && !axi_m.arvalid && !aa_rsp.awready &&
		!aa_rsp.wready && !aa_rsp.arready && !aa_rsp.rvalid && !wb_ack && user_prj_sel == 0)
		else begin
			other_errs++;
			$display("outputs not idle after reset at %0t", $time);
		end
	a_enable: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		(axi_m.awvalid || axi_m.arvalid) |->
		((tgt_en & ~en_mask) == 0) && ((en_mask == 0) || $onehot(tgt_en)))
		else begin
			value_errs++;
			$display("mismatch at %0t: target enable %b", $time, tgt_en);
		end
	a_awaddr: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		axi_m.awvalid && addr_chk |-> axi_m.awaddr == exp_addr)
		else begin
			value_errs++;
			$display("mismatch at %0t: outgoing write address", $time);
		end
	a_araddr: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		axi_m.arvalid && addr_chk |-> axi_m.araddr == exp_addr)
		else begin
			value_errs++;
			$display("mismatch at %0t: outgoing read address", $time);
		end
	a_wstrb: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		axi_m.wvalid |-> axi_m.wstrb == 4'hf)
		else begin
			value_errs++;
			$display("mismatch at %0t: write strobe %h", $time, axi_m.wstrb);
		end
	a_rready: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		any_rvalid |-> axi_m.rready)
		else begin
			other_errs++;
			$display("target read data offered while the master was not ready");
		end
	a_wb_data: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		wb_ack && wb_chk |-> wb_rdata == wb_exp)
		else begin
			value_errs++;
			$display("mismatch at %0t: wb read %h", $time, wb_rdata);
		end
	a_wb_ack_pulse: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		wb_ack |=> !wb_ack)
		else begin
			other_errs++;
			$display("wb ack held longer than one cycle");
		end
	a_sel: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		wb_ack |-> user_prj_sel == sel_shadow)
		else begin
			value_errs++;
			$display("mismatch at %0t: project select", $time);
		end
	a_aa_data: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		aa_rsp.rvalid && aa_chk |-> aa_rsp.rdata == aa_exp)
		else begin
			value_errs++;
			$display("mismatch at %0t: axil read data", $time);
		end
	a_rvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		aa_rsp.rvalid && !aa_req.rready |=> aa_rsp.rvalid && $stable(aa_rsp.rdata))
		else begin
			other_errs++;
			$display("rvalid dropped without rready");
		end
	a_wready_pulse: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		aa_rsp.wready |=> !aa_rsp.wready)
		else begin
			other_errs++;
			$display("wready held longer than one cycle");
		end

	always @(posedge axi_clk) begin
		if (wb_ack) wb_acks++;
		if (aa_rsp.wready || (aa_rsp.rvalid && aa_req.rready)) aa_dones++;
		if (m_active && !m_active_q) m_issues++; // New master transaction
		m_active_q = m_active;
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			other_errs++;
			$display("run did not finish within %0d cycles", MAX_CYCLES);
			$display("errors: %0d mismatch, %0d other", value_errs, other_errs);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// Requester tasks
	////////////////////////////////////////
	task automatic wb_xfer(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
	                       input logic [31:0] exp);
		@(posedge axi_clk);
		wb <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, wdata: wdata};
		wb_exp = exp;
		wb_chk = !we;
		started = 1'b1;
		wb_issued++;
		do @(negedge axi_clk); while (!wb_ack);
		@(posedge axi_clk);
		wb <= '0;
	endtask

	task automatic aa_write(input logic [31:0] addr, input logic [31:0] wdata);
		@(posedge axi_clk);
		aa_req.awvalid <= 1'b1;
		aa_req.awaddr  <= addr;
		started = 1'b1;
		aa_issued++;
		do @(negedge axi_clk); while (!aa_rsp.awready);
		@(posedge axi_clk);
		aa_req.awvalid <= 1'b0;
		aa_req.wvalid  <= 1'b1;
		aa_req.wdata   <= wdata;
		aa_req.wstrb   <= 4'hf;
		do @(negedge axi_clk); while (!aa_rsp.wready);
		@(posedge axi_clk);
		aa_req.wvalid <= 1'b0;
	endtask

	// A nonzero hold stalls rready once data is out on an external page
	task automatic aa_read(input logic [31:0] addr, input logic [31:0] exp, input int hold);
		@(posedge axi_clk);
		aa_req.arvalid <= 1'b1;
		aa_req.araddr  <= addr;
		aa_exp = exp;
		aa_chk = 1'b1;
		started = 1'b1;
		aa_issued++;
		do @(negedge axi_clk); while (!aa_rsp.arready);
		@(posedge axi_clk);
		aa_req.arvalid <= 1'b0;
		if (hold > 0) begin
			do @(negedge axi_clk); while (!any_rvalid);
			@(posedge axi_clk); // Master done
			@(posedge axi_clk); // rvalid rises here
			aa_req.rready <= 1'b0;
			repeat (hold) @(posedge axi_clk);
			aa_req.rready <= 1'b1;
		end
		do @(negedge axi_clk); while (!aa_rsp.rvalid);
		do @(negedge axi_clk); while (aa_rsp.rvalid);
	endtask

	task automatic single_setup(input logic [31:0] addr);
		en_mask  = page_mask(addr);
		addr_chk = 1'b1;
		exp_addr = addr[14:0];
	endtask

	initial begin
		logic [31:0] addr;
		logic [31:0] data;
		axi_clk     = 1'b0;
		axi_reset_n = 1'b0;
		wb          = '0;
		aa_req      = '0;
		aa_req.rready = 1'b1;
		for (int i = 0; i < 4; i++) shadow[i] = i * 32'h1111_1111;
		repeat (8) @(posedge axi_clk);
		axi_reset_n <= 1'b1;
		repeat (5) @(posedge axi_clk);

		// Write then read every external page from both ports
		for (int i = 0; i < 4; i++) begin
			addr = {20'h30000 + 20'(i), 12'h024};
			single_setup(addr);
			lcg_state = lcg_next(lcg_state);
			data = lcg_state;
			wb_xfer(1'b1, addr, data, '0);
			shadow[i] = data;
			wb_xfer(1'b0, addr, '0, shadow[i]);
			lcg_state = lcg_next(lcg_state);
			data = lcg_state;
			aa_write(addr, data);
			shadow[i] = data;
			aa_read(addr, shadow[i], 3);
		end

		// Local select register
		single_setup(32'h3000_4000);
		sel_shadow = 5'h1b;
		wb_xfer(1'b1, 32'h3000_4000, 32'hdead_bebb, '0);
		single_setup(32'h3000_4004);
		wb_xfer(1'b1, 32'h3000_4004, 32'h0000_0005, '0); // Wrong offset
		single_setup(32'h3000_4000);
		wb_xfer(1'b0, 32'h3000_4000, '0, {27'd0, sel_shadow});
		aa_read(32'h3000_4000, {27'd0, sel_shadow}, 0);

		// Reserved range
		single_setup(32'h3012_3008);
		wb_xfer(1'b0, 32'h3012_3008, '0, 32'hffff_ffff);
		single_setup(32'h3fff_f000);
		wb_xfer(1'b1, 32'h3fff_f000, 32'h1234_5678, '0);
		single_setup(32'h3000_5010);
		aa_read(32'h3000_5010, 32'hffff_ffff, 0);
		for (int i = 0; i < 4; i++) begin
			addr = {20'h30000 + 20'(i), 12'h024};
			single_setup(addr);
			wb_xfer(1'b0, addr, '0, shadow[i]);
		end

		// Both ports in the same cycle
		addr_chk = 1'b0;
		en_mask  = 4'b0011;
		fork
			wb_xfer(1'b0, 32'h3000_0024, '0, shadow[0]);
			aa_read(32'h3000_1024, shadow[1], 0);
		join
		en_mask = 4'b1100;
		fork
			wb_xfer(1'b1, 32'h3000_2024, 32'h0bad_f00d, '0);
			aa_write(32'h3000_3024, 32'h5eed_cafe);
		join
		shadow[2] = 32'h0bad_f00d;
		shadow[3] = 32'h5eed_cafe;
		fork
			wb_xfer(1'b0, 32'h3000_3024, '0, shadow[3]);
			aa_read(32'h3000_2024, shadow[2], 0);
		join

		repeat (5) @(posedge axi_clk);
		a_wb_count: assert (wb_acks == wb_issued)
			else begin
				other_errs++;
				$display("wb acks %0d for %0d requests", wb_acks, wb_issued);
			end
		a_aa_count: assert (aa_dones == aa_issued)
			else begin
				other_errs++;
				$display("axil completions %0d for %0d requests", aa_dones, aa_issued);
			end
		a_m_count: assert (m_issues == wb_issued + aa_issued)
			else begin
				other_errs++;
				$display("master issued %0d transactions for %0d requests",
					m_issues, wb_issued + aa_issued);
			end
		$display("errors: %0d mismatch, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
